//--- verilog/ppu_pkg.sv
// Shared definitions for the PPU pixel path.
// Register map, bus and coordinate widths, and pixel word types.

`default_nettype none

package ppu_pkg;

	localparam int W_COORD = 9;
	localparam int W_PIX = 15;
	localparam int W_LCD = 16;
	localparam int W_APB_ADDR = 16;
	localparam int W_APB_DATA = 32;

	// ----------------------------------------
	// Register offsets

	localparam logic [W_APB_ADDR-1:0] ADDR_CSR = 16'h0000;
	localparam logic [W_APB_ADDR-1:0] ADDR_DISPSIZE = 16'h0004;
	localparam logic [W_APB_ADDR-1:0] ADDR_DEFAULT_BG = 16'h0008;
	localparam logic [W_APB_ADDR-1:0] ADDR_LCD_PXFIFO = 16'h000c;
	localparam logic [W_APB_ADDR-1:0] ADDR_LCD_CSR = 16'h0010;

	// Palette window, entry taken from address bits 8:1
	localparam int PRAM_SEL_BIT = 11;

	// ----------------------------------------
	// Pixel words

	typedef struct packed {
		logic [4:0] r;
		logic [4:0] g;
		logic [4:0] b;
	} rgb555_t;

	typedef struct packed {
		logic [6:0] unused;
		logic [7:0] idx;
	} pal_ref_t;

	// Colour or palette index, selected by the paletted flag
	typedef union packed {
		rgb555_t rgb;
		pal_ref_t pal;
	} pix_word_t;

	typedef logic [W_LCD-1:0] lcd_word_t;

endpackage

`default_nettype wire

//--- verilog/ppu_pix_stream_if.sv
// Valid/ready pixel stream between pipeline stages

`timescale 1ns/1ps
`default_nettype none

interface ppu_pix_stream_if;
	import ppu_pkg::*;

	logic vld;
	logic rdy;
	pix_word_t data;
	logic paletted;

	// Source holds data while vld is high and rdy is low
	modport src (output vld, output data, output paletted, input rdy);
	modport dst (input vld, input data, input paletted, output rdy);

endinterface

`default_nettype wire

//--- verilog/ppu_apb_regs.sv
// APB register block for the PPU.
// Stored config, one-cycle control strobes, palette and FIFO write ports.

`timescale 1ns/1ps
`default_nettype none

module ppu_apb_regs (
	input  logic                          clk_ppu,
	input  logic                          rst_n_ppu,
	input  logic                          psel_i,
	input  logic                          penable_i,
	input  logic                          pwrite_i,
	input  logic [ppu_pkg::W_APB_ADDR-1:0] paddr_i,
	input  logic [ppu_pkg::W_APB_DATA-1:0] pwdata_i,
	output logic [ppu_pkg::W_APB_DATA-1:0] prdata_o,
	output logic                          pready_o,
	output logic                          pslverr_o,
	output logic                          run_o,
	output logic                          halt_o,
	output logic                          halt_vsync_o,
	output logic                          paletted_o,
	output logic [ppu_pkg::W_COORD-1:0]   disp_w_o,
	output logic [ppu_pkg::W_COORD-1:0]   disp_h_o,
	output ppu_pkg::pix_word_t            default_bg_o,
	input  logic                          running_i,
	output logic                          pal_wen_o,
	output logic [7:0]                    pal_waddr_o,
	output ppu_pkg::pix_word_t            pal_wdata_o,
	output logic                          direct_wen_o,
	output ppu_pkg::lcd_word_t            direct_wdata_o,
	input  logic                          fifo_empty_i,
	input  logic                          fifo_full_i,
	input  logic                          tx_busy_i,
	output logic                          lcd_cs_o,
	output logic                          lcd_dc_o
);
	import ppu_pkg::*;

	logic wr_en;
	logic pal_sel;
	logic mapped;

	assign wr_en = psel_i && penable_i && pwrite_i;
	assign pal_sel = paddr_i[PRAM_SEL_BIT];
	assign mapped = paddr_i inside {ADDR_CSR, ADDR_DISPSIZE, ADDR_DEFAULT_BG,
		ADDR_LCD_PXFIFO, ADDR_LCD_CSR};

	// Zero wait states
	assign pready_o = 1'b1;
	assign pslverr_o = psel_i && penable_i && !pal_sel && !mapped;

	// ----------------------------------------
	// Register writes

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			run_o <= 1'b0;
			halt_o <= 1'b0;
			halt_vsync_o <= 1'b0;
			paletted_o <= 1'b0;
			disp_w_o <= '0;
			disp_h_o <= '0;
			default_bg_o <= '0;
			lcd_cs_o <= 1'b1;
			lcd_dc_o <= 1'b0;
			pal_wen_o <= 1'b0;
			direct_wen_o <= 1'b0;
		end else begin
			// Strobes last one cycle
			run_o <= wr_en && paddr_i == ADDR_CSR && pwdata_i[0];
			halt_o <= wr_en && paddr_i == ADDR_CSR && pwdata_i[1];
			pal_wen_o <= wr_en && pal_sel;
			direct_wen_o <= wr_en && paddr_i == ADDR_LCD_PXFIFO;
			if (wr_en && paddr_i == ADDR_CSR) begin
				halt_vsync_o <= pwdata_i[2];
				paletted_o <= pwdata_i[3];
			end
			if (wr_en && paddr_i == ADDR_DISPSIZE) begin
				disp_w_o <= pwdata_i[W_COORD-1:0];
				disp_h_o <= pwdata_i[16 +: W_COORD];
			end
			if (wr_en && paddr_i == ADDR_DEFAULT_BG)
				default_bg_o <= pwdata_i[W_PIX-1:0];
			if (wr_en && paddr_i == ADDR_LCD_CSR) begin
				lcd_cs_o <= pwdata_i[16];
				lcd_dc_o <= pwdata_i[17];
			end
		end
	end

	// Write payloads, qualified by the strobes above
	always_ff @(posedge clk_ppu) begin
		pal_waddr_o <= paddr_i[8:1];
		pal_wdata_o <= pwdata_i[W_PIX-1:0];
		direct_wdata_o <= pwdata_i[W_LCD-1:0];
	end

	// ----------------------------------------
	// Read mux

	always_comb begin
		prdata_o = '0;
		if (!pal_sel) begin
			case (paddr_i)
				ADDR_CSR: prdata_o[3:0] = {paletted_o, halt_vsync_o, 1'b0, running_i};
				ADDR_DISPSIZE: begin
					prdata_o[W_COORD-1:0] = disp_w_o;
					prdata_o[16 +: W_COORD] = disp_h_o;
				end
				ADDR_DEFAULT_BG: prdata_o[W_PIX-1:0] = default_bg_o;
				ADDR_LCD_CSR: begin
					prdata_o[0] = fifo_empty_i;
					prdata_o[1] = fifo_full_i;
					prdata_o[8] = tx_busy_i;
					prdata_o[16] = lcd_cs_o;
					prdata_o[17] = lcd_dc_o;
				end
				default: prdata_o = '0;
			endcase
		end
	end

	// APB access phase always follows a selected setup phase
	assert property (@(posedge clk_ppu) disable iff (!rst_n_ppu) penable_i |-> psel_i);

endmodule

`default_nettype wire

//--- verilog/ppu_raster_source.sv
// Run/halt control, x/y raster counter and default colour fill

`timescale 1ns/1ps
`default_nettype none

module ppu_raster_source (
	input  logic                        clk_ppu,
	input  logic                        rst_n_ppu,
	input  logic                        run_i,
	input  logic                        halt_i,
	input  logic                        halt_vsync_i,
	input  logic                        paletted_i,
	input  logic [ppu_pkg::W_COORD-1:0] disp_w_i,
	input  logic [ppu_pkg::W_COORD-1:0] disp_h_i,
	input  ppu_pkg::pix_word_t          default_bg_i,
	output logic                        running_o,
	ppu_pix_stream_if.src               pix
);
	import ppu_pkg::*;

	logic [W_COORD-1:0] x;
	logic [W_COORD-1:0] y;
	logic xfer;
	logic last_x;
	logic frame_end;

	assign xfer = pix.vld && pix.rdy;
	// Compare with >= so a shrunk display size still wraps
	assign last_x = x >= disp_w_i;
	assign frame_end = xfer && last_x && y >= disp_h_i;

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			running_o <= 1'b0;
		end else if (halt_i) begin
			running_o <= 1'b0;
		end else if (run_i) begin
			running_o <= 1'b1;
		end else if (halt_vsync_i && frame_end) begin
			running_o <= 1'b0;
		end
	end

	// Raster position only moves on an accepted pixel
	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			x <= '0;
			y <= '0;
		end else if (xfer) begin
			if (last_x) begin
				x <= '0;
				y <= (y >= disp_h_i) ? '0 : y + 1'b1;
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	// No layers, so every position gets the background colour
	assign pix.vld = running_o;
	assign pix.data = default_bg_i;
	assign pix.paletted = paletted_i;

	assert property (@(posedge clk_ppu) disable iff (!rst_n_ppu)
		running_o |-> x <= disp_w_i);

endmodule

`default_nettype wire

//--- verilog/ppu_palette_mapper.sv
// Palette RAM and registered lookup stage.
// Turns pixel words into LCD words.

`timescale 1ns/1ps
`default_nettype none

module ppu_palette_mapper (
	input  logic                 clk_ppu,
	input  logic                 rst_n_ppu,
	input  logic                 pal_wen_i,
	input  logic [7:0]           pal_waddr_i,
	input  ppu_pkg::pix_word_t   pal_wdata_i,
	ppu_pix_stream_if.dst        pix,
	output logic                 out_vld_o,
	input  logic                 out_rdy_i,
	output ppu_pkg::lcd_word_t   out_data_o
);
	import ppu_pkg::*;

	logic [W_PIX-1:0] pram [256];
	rgb555_t colour;
	logic in_xfer;

	// Red, green, a zero pad bit, then blue
	function automatic lcd_word_t to_lcd(input rgb555_t c);
		to_lcd = {c.r, c.g, 1'b0, c.b};
	endfunction

	always_ff @(posedge clk_ppu) begin
		if (pal_wen_i)
			pram[pal_waddr_i] <= pal_wdata_i;
	end

	// Output register stalls while the FIFO is full
	assign pix.rdy = !out_vld_o || out_rdy_i;
	assign in_xfer = pix.vld && pix.rdy;

	assign colour = pix.paletted ? rgb555_t'(pram[pix.data.pal.idx]) : pix.data.rgb;

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu)
			out_vld_o <= 1'b0;
		else if (in_xfer)
			out_vld_o <= 1'b1;
		else if (out_rdy_i)
			out_vld_o <= 1'b0;
	end

	always_ff @(posedge clk_ppu) begin
		if (in_xfer)
			out_data_o <= to_lcd(colour);
	end

endmodule

`default_nettype wire

//--- verilog/ppu_pixel_fifo.sv
// Synchronous pixel FIFO.
// Software direct writes take priority over the pipeline port.

`timescale 1ns/1ps
`default_nettype none

module ppu_pixel_fifo #(
	parameter int DEPTH = 8
) (
	input  logic               clk_ppu,
	input  logic               rst_n_ppu,
	input  logic               direct_wen_i,
	input  ppu_pkg::lcd_word_t direct_wdata_i,
	input  logic               in_vld_i,
	output logic               in_rdy_o,
	input  ppu_pkg::lcd_word_t in_data_i,
	output logic               out_vld_o,
	input  logic               out_rdy_i,
	output ppu_pkg::lcd_word_t out_data_o,
	output logic               empty_o,
	output logic               full_o
);
	import ppu_pkg::*;

	localparam int W_PTR = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int W_LEVEL = $clog2(DEPTH + 1);

	lcd_word_t mem [DEPTH];
	logic [W_PTR-1:0] wr_ptr;
	logic [W_PTR-1:0] rd_ptr;
	logic [W_LEVEL-1:0] level;
	logic wen;
	logic ren;

	assign empty_o = level == '0;
	assign full_o = level == W_LEVEL'(DEPTH);
	assign in_rdy_o = !full_o && !direct_wen_i;
	assign wen = direct_wen_i || (in_vld_i && in_rdy_o);
	assign out_vld_o = !empty_o;
	assign ren = out_vld_o && out_rdy_i;
	assign out_data_o = mem[rd_ptr];

	always_ff @(posedge clk_ppu) begin
		if (wen)
			mem[wr_ptr] <= direct_wen_i ? direct_wdata_i : in_data_i;
	end

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (wen)
				wr_ptr <= (wr_ptr == W_PTR'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (ren)
				rd_ptr <= (rd_ptr == W_PTR'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({wen, ren})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	// Software must poll the full flag before writing
	assert property (@(posedge clk_ppu) disable iff (!rst_n_ppu) direct_wen_i |-> !full_o);

endmodule

`default_nettype wire

//--- verilog/ppu_lcd_shifter.sv
// Serial LCD shifter.
// 16-bit words, MSB first, sck at half the clock rate.

`timescale 1ns/1ps
`default_nettype none

module ppu_lcd_shifter (
	input  logic               clk_ppu,
	input  logic               rst_n_ppu,
	input  logic               in_vld_i,
	output logic               in_rdy_o,
	input  ppu_pkg::lcd_word_t in_data_i,
	output logic               tx_busy_o,
	output logic               lcd_sck_o,
	output logic               lcd_mosi_o
);
	import ppu_pkg::*;

	lcd_word_t sreg;
	// Even count is the sck low phase, odd is high
	logic [4:0] cnt;
	logic load;

	assign in_rdy_o = !tx_busy_o;
	assign load = in_vld_i && in_rdy_o;

	always_ff @(posedge clk_ppu or negedge rst_n_ppu) begin
		if (!rst_n_ppu) begin
			tx_busy_o <= 1'b0;
			lcd_sck_o <= 1'b0;
			lcd_mosi_o <= 1'b0;
			cnt <= '0;
		end else if (load) begin
			tx_busy_o <= 1'b1;
			lcd_sck_o <= 1'b0;
			lcd_mosi_o <= in_data_i[W_LCD-1];
			cnt <= '0;
		end else if (tx_busy_o) begin
			cnt <= cnt + 1'b1;
			lcd_sck_o <= !cnt[0];
			// Next bit goes out as sck falls
			if (cnt[0])
				lcd_mosi_o <= sreg[W_LCD-1];
			if (cnt == 5'd31)
				tx_busy_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_ppu) begin
		if (load)
			sreg <= {in_data_i[W_LCD-2:0], 1'b0};
		else if (tx_busy_o && cnt[0])
			sreg <= {sreg[W_LCD-2:0], 1'b0};
	end

endmodule

`default_nettype wire

//--- verilog/riscboy_ppu_lite.sv
// PPU pixel path top level.
// APB registers, raster source, palette mapper, pixel FIFO and LCD shifter.

`timescale 1ns/1ps
`default_nettype none

module riscboy_ppu_lite #(
	parameter int PXFIFO_DEPTH = 8
) (
	input  logic                           clk_ppu,
	input  logic                           rst_n_ppu,
	input  logic                           apbs_psel_i,
	input  logic                           apbs_penable_i,
	input  logic                           apbs_pwrite_i,
	input  logic [ppu_pkg::W_APB_ADDR-1:0] apbs_paddr_i,
	input  logic [ppu_pkg::W_APB_DATA-1:0] apbs_pwdata_i,
	output logic [ppu_pkg::W_APB_DATA-1:0] apbs_prdata_o,
	output logic                           apbs_pready_o,
	output logic                           apbs_pslverr_o,
	output logic                           lcd_cs_o,
	output logic                           lcd_dc_o,
	output logic                           lcd_sck_o,
	output logic                           lcd_mosi_o
);
	import ppu_pkg::*;

	logic run;
	logic halt;
	logic halt_vsync;
	logic paletted;
	logic running;
	logic [W_COORD-1:0] disp_w;
	logic [W_COORD-1:0] disp_h;
	pix_word_t default_bg;

	logic pal_wen;
	logic [7:0] pal_waddr;
	pix_word_t pal_wdata;

	logic direct_wen;
	lcd_word_t direct_wdata;
	logic fifo_empty;
	logic fifo_full;
	logic tx_busy;

	logic pmap_vld;
	logic pmap_rdy;
	lcd_word_t pmap_data;
	logic lcd_vld;
	logic lcd_rdy;
	lcd_word_t lcd_data;

	ppu_pix_stream_if pix_if ();

	// ----------------------------------------
	// Registers

	ppu_apb_regs u_regs (
		.clk_ppu        (clk_ppu),
		.rst_n_ppu      (rst_n_ppu),
		.psel_i         (apbs_psel_i),
		.penable_i      (apbs_penable_i),
		.pwrite_i       (apbs_pwrite_i),
		.paddr_i        (apbs_paddr_i),
		.pwdata_i       (apbs_pwdata_i),
		.prdata_o       (apbs_prdata_o),
		.pready_o       (apbs_pready_o),
		.pslverr_o      (apbs_pslverr_o),
		.run_o          (run),
		.halt_o         (halt),
		.halt_vsync_o   (halt_vsync),
		.paletted_o     (paletted),
		.disp_w_o       (disp_w),
		.disp_h_o       (disp_h),
		.default_bg_o   (default_bg),
		.running_i      (running),
		.pal_wen_o      (pal_wen),
		.pal_waddr_o    (pal_waddr),
		.pal_wdata_o    (pal_wdata),
		.direct_wen_o   (direct_wen),
		.direct_wdata_o (direct_wdata),
		.fifo_empty_i   (fifo_empty),
		.fifo_full_i    (fifo_full),
		.tx_busy_i      (tx_busy),
		.lcd_cs_o       (lcd_cs_o),
		.lcd_dc_o       (lcd_dc_o)
	);

	// ----------------------------------------
	// Pixel pipeline

	ppu_raster_source u_source (
		.clk_ppu      (clk_ppu),
		.rst_n_ppu    (rst_n_ppu),
		.run_i        (run),
		.halt_i       (halt),
		.halt_vsync_i (halt_vsync),
		.paletted_i   (paletted),
		.disp_w_i     (disp_w),
		.disp_h_i     (disp_h),
		.default_bg_i (default_bg),
		.running_o    (running),
		.pix          (pix_if.src)
	);

	ppu_palette_mapper u_pmap (
		.clk_ppu     (clk_ppu),
		.rst_n_ppu   (rst_n_ppu),
		.pal_wen_i   (pal_wen),
		.pal_waddr_i (pal_waddr),
		.pal_wdata_i (pal_wdata),
		.pix         (pix_if.dst),
		.out_vld_o   (pmap_vld),
		.out_rdy_i   (pmap_rdy),
		.out_data_o  (pmap_data)
	);

	ppu_pixel_fifo #(
		.DEPTH (PXFIFO_DEPTH)
	) u_fifo (
		.clk_ppu        (clk_ppu),
		.rst_n_ppu      (rst_n_ppu),
		.direct_wen_i   (direct_wen),
		.direct_wdata_i (direct_wdata),
		.in_vld_i       (pmap_vld),
		.in_rdy_o       (pmap_rdy),
		.in_data_i      (pmap_data),
		.out_vld_o      (lcd_vld),
		.out_rdy_i      (lcd_rdy),
		.out_data_o     (lcd_data),
		.empty_o        (fifo_empty),
		.full_o         (fifo_full)
	);

	ppu_lcd_shifter u_lcd (
		.clk_ppu    (clk_ppu),
		.rst_n_ppu  (rst_n_ppu),
		.in_vld_i   (lcd_vld),
		.in_rdy_o   (lcd_rdy),
		.in_data_i  (lcd_data),
		.tx_busy_o  (tx_busy),
		.lcd_sck_o  (lcd_sck_o),
		.lcd_mosi_o (lcd_mosi_o)
	);

endmodule

`default_nettype wire

//--- sim/tb_ppu.sv
// Directed testbench for the PPU pixel path.
// APB driver tasks, LCD word monitor, colour model and the tests.

`timescale 1ns/1ps
`default_nettype none

module tb_ppu;
	import ppu_pkg::*;

	localparam int PXFIFO_DEPTH = 8;
	localparam int CLK_PERIOD = 100;
	localparam int FRAME_WORDS = 8;

	logic clk_ppu;
	logic rst_n_ppu;
	logic psel;
	logic penable;
	logic pwrite;
	logic [W_APB_ADDR-1:0] paddr;
	logic [W_APB_DATA-1:0] pwdata;
	logic [W_APB_DATA-1:0] prdata;
	logic pready;
	logic pslverr;
	logic lcd_cs;
	logic lcd_dc;
	logic lcd_sck;
	logic lcd_mosi;

	logic [15:0] words[$];
	logic [31:0] lcg_state;
	logic [14:0] bg_colour;

	riscboy_ppu_lite #(
		.PXFIFO_DEPTH (PXFIFO_DEPTH)
	) u_riscboy_ppu_lite (
		.clk_ppu        (clk_ppu),
		.rst_n_ppu      (rst_n_ppu),
		.apbs_psel_i    (psel),
		.apbs_penable_i (penable),
		.apbs_pwrite_i  (pwrite),
		.apbs_paddr_i   (paddr),
		.apbs_pwdata_i  (pwdata),
		.apbs_prdata_o  (prdata),
		.apbs_pready_o  (pready),
		.apbs_pslverr_o (pslverr),
		.lcd_cs_o       (lcd_cs),
		.lcd_dc_o       (lcd_dc),
		.lcd_sck_o      (lcd_sck),
		.lcd_mosi_o     (lcd_mosi)
	);

	always #(CLK_PERIOD / 2) clk_ppu = ~clk_ppu;

	// ----------------------------------------
	// Error reporting

	task automatic stop_with_failure();
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped after an error");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0t while waiting for %s", $time, what);
		stop_with_failure();
	endtask

	// ----------------------------------------
	// Stimulus helpers

	// LCG, upper bits give the colour
	function automatic logic [14:0] next_colour();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:16];
	endfunction

	// LCD word is red, green, a zero bit, then blue
	function automatic logic [15:0] expected_lcd(input logic [14:0] c);
		return {c[14:10], c[9:5], 1'b0, c[4:0]};
	endfunction

	task automatic apb_write(input logic [15:0] addr, input logic [31:0] data);
		@(posedge clk_ppu);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge clk_ppu);
		#1;
		penable = 1'b1;
		@(posedge clk_ppu);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [15:0] addr, output logic [31:0] data,
		output logic err);
		logic rdy;
		@(posedge clk_ppu);
		#1;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge clk_ppu);
		#1;
		penable = 1'b1;
		// Read data is combinational, sample mid access phase
		@(negedge clk_ppu);
		data = prdata;
		err = pslverr;
		rdy = pready;
		check_value("pready in access phase", rdy, 1'b1);
		@(posedge clk_ppu);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	// Rising sck is seen at the falling clock edge after it
	task automatic lcd_monitor();
		logic [15:0] shreg;
		int nbits;
		logic sck_prev;
		shreg = '0;
		nbits = 0;
		sck_prev = 1'b0;
		forever begin
			@(negedge clk_ppu);
			if (lcd_sck && !sck_prev) begin
				shreg = {shreg[14:0], lcd_mosi};
				nbits++;
				if (nbits == 16) begin
					words.push_back(shreg);
					nbits = 0;
				end
			end
			sck_prev = lcd_sck;
		end
	endtask

	task automatic wait_for_words(input int n, input int limit, input string what);
		int cycles;
		cycles = 0;
		while (words.size() < n) begin
			if (cycles >= limit) begin
				report_timeout(what);
			end else begin
				@(posedge clk_ppu);
				cycles++;
			end
		end
	endtask

	// Polls LCD_CSR until the masked status bits match
	task automatic wait_lcd_status(input logic [31:0] mask, input logic [31:0] want,
		input int limit, input string what);
		logic [31:0] rd;
		logic err;
		int cycles;
		cycles = 0;
		rd = ~want;
		while ((rd & mask) !== want) begin
			if (cycles >= limit) begin
				report_timeout(what);
			end else begin
				apb_read(ADDR_LCD_CSR, rd, err);
				cycles += 3;
			end
		end
	endtask

	task automatic check_frame(input logic [15:0] exp, input string what);
		logic [31:0] rd;
		logic err;
		wait_for_words(FRAME_WORDS, 600, what);
		for (int i = 0; i < FRAME_WORDS; i++)
			check_value($sformatf("%s word %0d", what, i), words[i], exp);
		apb_read(ADDR_CSR, rd, err);
		check_value("running after frame", rd[0], 1'b0);
	endtask

	// ----------------------------------------
	// Tests

	task automatic register_access();
		logic [31:0] rd;
		logic err;
		apb_read(ADDR_LCD_CSR, rd, err);
		check_value("LCD_CSR after reset", rd & 32'h0003_0103, 32'h0001_0001);
		check_value("pslverr on LCD_CSR", err, 1'b0);
		check_value("lcd_cs_o after reset", lcd_cs, 1'b1);
		check_value("lcd_dc_o after reset", lcd_dc, 1'b0);
		apb_write(ADDR_DISPSIZE, 32'h0123_00ab);
		apb_read(ADDR_DISPSIZE, rd, err);
		check_value("DISPSIZE", rd, 32'h0123_00ab);
		// Bit 15 is not stored
		apb_write(ADDR_DEFAULT_BG, 32'hffff_da3c);
		apb_read(ADDR_DEFAULT_BG, rd, err);
		check_value("DEFAULT_BG", rd, 32'h0000_5a3c);
		apb_write(ADDR_LCD_CSR, 32'h0002_0000);
		apb_read(ADDR_LCD_CSR, rd, err);
		check_value("LCD_CSR cs/dc", rd[17:16], 2'b10);
		check_value("lcd_cs_o", lcd_cs, 1'b0);
		check_value("lcd_dc_o", lcd_dc, 1'b1);
		apb_write(ADDR_LCD_CSR, 32'h0001_0000);
		check_value("lcd_cs_o restored", lcd_cs, 1'b1);
		check_value("lcd_dc_o restored", lcd_dc, 1'b0);
		apb_read(16'h0014, rd, err);
		check_value("pslverr on unmapped offset", err, 1'b1);
	endtask

	task automatic direct_write_path();
		logic [31:0] rd;
		logic err;
		words.delete();
		apb_write(ADDR_LCD_PXFIFO, 32'h0000_a5c3);
		wait_for_words(1, 200, "direct write word");
		check_value("direct write word", words[0], 16'ha5c3);
		wait_lcd_status(32'h0000_0100, 32'h0000_0000, 200, "tx idle after direct write");
		apb_read(ADDR_LCD_CSR, rd, err);
		check_value("FIFO empty after direct write", rd[0], 1'b1);
	endtask

	task automatic direct_colour_frame();
		words.delete();
		bg_colour = next_colour();
		// 4 by 2 screen
		apb_write(ADDR_DISPSIZE, 32'h0001_0003);
		apb_write(ADDR_DEFAULT_BG, {17'h0, bg_colour});
		apb_write(ADDR_CSR, 32'h0000_0005);
		check_frame(expected_lcd(bg_colour), "direct frame");
		repeat (200) @(posedge clk_ppu);
		check_value("words after frame end", words.size(), FRAME_WORDS);
	endtask

	task automatic paletted_frame();
		logic [14:0] pal_colour;
		logic [15:0] pal_addr;
		words.delete();
		pal_colour = next_colour();
		pal_addr = 16'h0800 | {7'h0, bg_colour[7:0], 1'b0};
		apb_write(pal_addr, {17'h0, pal_colour});
		apb_write(ADDR_CSR, 32'h0000_000d);
		check_frame(expected_lcd(pal_colour), "paletted frame");
	endtask

	task automatic halt_mid_frame();
		logic [31:0] rd;
		logic err;
		int n_halt;
		int n_end;
		words.delete();
		apb_write(ADDR_CSR, 32'h0000_0001);
		wait_for_words(1, 200, "first word before halt");
		apb_write(ADDR_CSR, 32'h0000_0002);
		n_halt = words.size();
		apb_read(ADDR_CSR, rd, err);
		check_value("running after halt", rd[0], 1'b0);
		// Shifter, FIFO and mapper register drain, then silence
		wait_lcd_status(32'h0000_0101, 32'h0000_0001, 400, "stream to stop after halt");
		n_end = words.size();
		// Words queued under back-pressure keep their colour
		for (int i = 0; i < n_end; i++)
			check_value($sformatf("halt word %0d", i), words[i], expected_lcd(bg_colour));
		repeat (100) @(posedge clk_ppu);
		check_value("words after stream stopped", words.size(), n_end);
		assert (n_end - n_halt <= PXFIFO_DEPTH + 2) else begin
			$display("[FAIL] %0t: %0d words after halt, at most %0d allowed",
				$time, n_end - n_halt, PXFIFO_DEPTH + 2);
			stop_with_failure();
		end
	endtask

	// ----------------------------------------
	// Main sequence

	initial lcd_monitor();

	initial begin
		clk_ppu = 1'b0;
		rst_n_ppu = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		lcg_state = 32'd60;
		bg_colour = '0;
		repeat (4) @(posedge clk_ppu);
		#1;
		rst_n_ppu = 1'b1;

		register_access();
		direct_write_path();
		direct_colour_frame();
		paletted_frame();
		halt_mid_frame();

		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
verilog/ppu_pkg.sv
verilog/ppu_pix_stream_if.sv
verilog/ppu_apb_regs.sv
verilog/ppu_raster_source.sv
verilog/ppu_palette_mapper.sv
verilog/ppu_pixel_fifo.sv
verilog/ppu_lcd_shifter.sv
verilog/riscboy_ppu_lite.sv
sim/tb_ppu.sv

//--- Makefile
# Verilator build and run for the PPU pixel path testbench

VERILATOR ?= verilator
TOP       ?= tb_ppu
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
